// File: vlog.f
hw/ls_core_pkg.sv
hw/instr_decoder.sv
hw/fetch_sequencer.sv
hw/load_store_unit.sv
hw/reg_file.sv
hw/mem_arbiter.sv
hw/data_ram.sv
hw/ls_core_top.sv
verification/tb_ls_core.sv

// File: verification/ls_core_golden.txt
# W addr byteenable data : host write | R addr expected : host read and compare
# E reg data : next expected retire | X count busy : run count instructions, host reads if busy=1
W 00000100 f 8192A3B4
W 00000104 f 11223344
W 00000108 f 55667788
W 00000108 5 AABBCCDD
W 0000010C f DEADBEEF
R 00000100 8192A3B4
R 00000108 55BB77DD
# Program at address 0
W 00000000 f 80010100
W 00000004 f 80020101
W 00000008 f 90030102
W 0000000C f 90040103
W 00000010 f 80050107
W 00000014 f 84060100
W 00000018 f 94070102
W 0000001C f 84080106
W 00000020 f 8C090100
W 00000024 f 3C0ABEEF
W 00000028 f 88010105
W 0000002C f 88020106
W 00000030 f 88030107
W 00000034 f 88040104
W 00000038 f 98050104
W 0000003C f 98060105
W 00000040 f 98070106
W 00000044 f 98080107
W 00000048 f A009010D
W 0000004C f A407010E
W 00000050 f AC0A0110
W 00000054 f 8C000100
W 00000058 f FFFFFFFF
W 0000005C f 80AB00FC
# Byte, half, word loads and LUI
E 01 FFFFFF81
E 02 FFFFFF92
E 03 000000A3
E 04 000000B4
E 05 00000044
E 06 FFFF8192
E 07 0000A3B4
E 08 00003344
E 09 8192A3B4
E 0A BEEF0000
X 10 0
# LWL and LWR at every offset, host reads competing
E 01 22334481
E 02 3344FF92
E 03 440000A3
E 04 11223344
E 05 00000011
E 06 FFFF1122
E 07 00112233
E 08 11223344
X 8 1
# Stores, load to r0, unknown opcode, then a based load
E 0B FFFFFFB4
X 6 1
R 0000010C DEB42233
R 00000110 BEEF0000
R 00000104 11223344
R 00000100 8192A3B4

// File: verification/tb_ls_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ls_core import ls_core_pkg::*; ();

    localparam string GOLDEN_FILE = "verification/ls_core_golden.txt";

    logic     clk;
    logic     rst_n;
    logic     run;
    logic     host_read;
    logic     host_write;
    addr_t    host_address;
    byte_en_t host_byteenable;
    word_t    host_writedata;
    word_t    host_readdata;
    logic     host_waitrequest;
    logic     retire_valid;
    reg_idx_t retire_reg;
    word_t    retire_data;

    reg_idx_t exp_reg_q[$];    // Expected retires in order
    word_t    exp_data_q[$];
    int       errors;
    int       tests;
    int       failed_tests;
    int       wd_cycles;
    integer   seed;
    logic     run_done;
    addr_t    probe_addr;      // Last word checked by a host read
    word_t    probe_data;

    ls_core_top #(.MEM_WORDS(256), .RESET_PC(32'h0)) u_ls_core_top (
        .clk (clk), .rst_n (rst_n), .run (run),
        .host_read (host_read), .host_write (host_write), .host_address (host_address),
        .host_byteenable (host_byteenable), .host_writedata (host_writedata),
        .host_readdata (host_readdata), .host_waitrequest (host_waitrequest),
        .retire_valid (retire_valid), .retire_reg (retire_reg), .retire_data (retire_data)
    );

    always #5 clk = ~clk;

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("PASS  test %0d: %s", tests, name);
        end else begin
            failed_tests++;
            $display("FAIL  test %0d: %s", tests, name);
        end
    endtask

    // One host transfer with read data sampled the cycle after the grant
    task automatic host_access(input logic wr, input addr_t addr, input byte_en_t be,
                               input word_t wdata, output word_t rdata);
        @(posedge clk);
        host_read       <= !wr;
        host_write      <= wr;
        host_address    <= addr;
        host_byteenable <= be;
        host_writedata  <= wdata;
        @(negedge clk);
        check_value(host_waitrequest, 1'b0, "host waitrequest");   // Host has top priority
        while (host_waitrequest) begin
            @(negedge clk);
        end
        @(posedge clk);
        host_read  <= 1'b0;
        host_write <= 1'b0;
        @(negedge clk);
        rdata = host_readdata;
    endtask

    task automatic run_program(input int count, input int busy);
        int    seen;
        int    gap;
        word_t rdata;
        seen     = 0;
        run_done = 1'b0;
        fork
            begin
                @(posedge clk);
                run <= 1'b1;
                while (seen < count) begin
                    @(negedge clk);
                    if (u_ls_core_top.phase == EXEC2) begin   // Every instruction ends here
                        seen++;
                    end
                end
                @(posedge clk);
                run <= 1'b0;   // Core parks in FETCH
                run_done = 1'b1;
            end
            begin
                while (busy != 0 && !run_done) begin
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap) @(posedge clk);
                    host_access(1'b0, probe_addr, 4'b1111, '0, rdata);
                    check_value(rdata, probe_data, "host read during run");
                end
            end
        join
        @(posedge clk);
        check_value(exp_data_q.size(), 0, "retires still expected after run");
    endtask

    // Retire trace against the queued expectations
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            if (exp_reg_q.size() == 0) begin
                $display("Unexpected retire to r%0d with %h at %0t ns",
                         retire_reg, retire_data, $time);
                errors++;
            end else begin
                check_value(retire_reg, exp_reg_q.pop_front(), "retire register");
                check_value(retire_data, exp_data_q.pop_front(), "retire data");
            end
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles before the golden file was done", wd_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int         fd;
        int         n;
        int         count;
        int         busy;
        int         total;
        int         err_before;
        logic [7:0] cmd;
        word_t      a;
        word_t      b;
        word_t      c;
        word_t      rdata;
        string      line;

        clk             = 1'b0;
        rst_n           = 1'b0;
        run             = 1'b0;
        host_read       = 1'b0;
        host_write      = 1'b0;
        host_address    = '0;
        host_byteenable = '0;
        host_writedata  = '0;
        errors          = 0;
        tests           = 0;
        failed_tests    = 0;
        wd_cycles       = 0;
        seed            = 32'h3588;
        run_done        = 1'b0;
        probe_addr      = '0;
        probe_data      = '0;
        total           = 0;

        // First pass sizes the watchdog
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s", GOLDEN_FILE);
            errors++;
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                if (cmd == "X") begin
                    n = $fscanf(fd, "%d", count);
                    total += count;
                end else if (cmd == "W" || cmd == "R") begin
                    total++;
                end
                n = $fgets(line, fd);
            end
            $fclose(fd);
            wd_cycles = 20 * total + 100;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Idle state right after reset
        @(negedge clk);
        err_before = errors;
        check_value(retire_valid, 1'b0, "retire_valid after reset");
        check_value(host_waitrequest, 1'b0, "host_waitrequest after reset");
        check_value(u_ls_core_top.phase, FETCH, "phase after reset");
        report_test("reset state", err_before);

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd != 0) begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                err_before = errors;
                case (cmd)
                    "#": n = $fgets(line, fd);
                    "E": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        exp_reg_q.push_back(a[4:0]);
                        exp_data_q.push_back(b);
                    end
                    "W": begin
                        n = $fscanf(fd, "%h %h %h", a, b, c);
                        host_access(1'b1, a, b[3:0], c, rdata);
                        report_test($sformatf("host write %h", a), err_before);
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h", a, b);
                        host_access(1'b0, a, 4'b1111, '0, rdata);
                        check_value(rdata, b, $sformatf("host read %h", a));
                        probe_addr = a;
                        probe_data = b;
                        report_test($sformatf("host read %h", a), err_before);
                    end
                    "X": begin
                        n = $fscanf(fd, "%d %d", count, busy);
                        run_program(count, busy);
                        report_test($sformatf("run %0d instructions, host busy %0d",
                                              count, busy), err_before);
                    end
                    default: begin
                        $display("Unknown command '%c' in the golden file", cmd);
                        errors++;
                        n = $fgets(line, fd);
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (2) @(posedge clk);
        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/ls_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ls_core_top import ls_core_pkg::*; #(
    parameter int    MEM_WORDS = 256,
    parameter addr_t RESET_PC  = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run,
    input  logic     host_read,
    input  logic     host_write,
    input  addr_t    host_address,
    input  byte_en_t host_byteenable,
    input  word_t    host_writedata,
    output word_t    host_readdata,
    output logic     host_waitrequest,
    output logic     retire_valid,
    output reg_idx_t retire_reg,
    output word_t    retire_data
);

    cpu_phase_e phase;
    word_t      instr;
    ls_op_e     ls_op;
    reg_idx_t   rs;
    reg_idx_t   rt;
    imm_t       offset;
    word_t      rs_data;
    word_t      rt_data;
    logic       fetch_read;
    logic       fetch_wait;
    addr_t      fetch_address;
    logic       lsu_read;
    logic       lsu_write;
    logic       lsu_wait;
    addr_t      lsu_address;
    byte_en_t   lsu_byteenable;
    word_t      lsu_writedata;
    logic       ram_read;
    logic       ram_write;
    addr_t      ram_address;
    byte_en_t   ram_byteenable;
    word_t      ram_writedata;
    word_t      ram_readdata;

    assign host_readdata = ram_readdata;

    // PC is the fetch address as well, so the pc port is left open
    fetch_sequencer #(.RESET_PC(RESET_PC)) u_fetch_sequencer (
        .clk (clk), .rst_n (rst_n), .run (run),
        .mem_readdata (ram_readdata), .mem_waitrequest (fetch_wait),
        .phase (phase), .instr (instr), .pc (),
        .mem_read (fetch_read), .mem_address (fetch_address)
    );

    instr_decoder u_instr_decoder (
        .instr (instr), .ls_op (ls_op), .rs (rs), .rt (rt), .offset (offset)
    );

    load_store_unit u_load_store_unit (
        .phase (phase), .ls_op (ls_op), .rt (rt), .offset (offset),
        .rs_data (rs_data), .rt_data (rt_data),
        .mem_readdata (ram_readdata), .mem_waitrequest (lsu_wait),
        .mem_read (lsu_read), .mem_write (lsu_write), .mem_address (lsu_address),
        .mem_byteenable (lsu_byteenable), .mem_writedata (lsu_writedata),
        .reg_we (retire_valid), .reg_waddr (retire_reg), .reg_wdata (retire_data)
    );

    reg_file u_reg_file (
        .clk (clk), .rst_n (rst_n), .raddr_a (rs), .raddr_b (rt),
        .we (retire_valid), .waddr (retire_reg), .wdata (retire_data),
        .rdata_a (rs_data), .rdata_b (rt_data)
    );

    mem_arbiter u_mem_arbiter (
        .host_read (host_read), .host_write (host_write), .host_address (host_address),
        .host_byteenable (host_byteenable), .host_writedata (host_writedata),
        .host_waitrequest (host_waitrequest),
        .fetch_read (fetch_read), .fetch_write (1'b0), .fetch_address (fetch_address),
        .fetch_byteenable (4'b1111), .fetch_writedata ('0),
        .fetch_waitrequest (fetch_wait),
        .lsu_read (lsu_read), .lsu_write (lsu_write), .lsu_address (lsu_address),
        .lsu_byteenable (lsu_byteenable), .lsu_writedata (lsu_writedata),
        .lsu_waitrequest (lsu_wait),
        .ram_read (ram_read), .ram_write (ram_write), .ram_address (ram_address),
        .ram_byteenable (ram_byteenable), .ram_writedata (ram_writedata)
    );

    data_ram #(.MEM_WORDS(MEM_WORDS)) u_data_ram (
        .clk (clk), .read (ram_read), .write (ram_write), .address (ram_address),
        .byteenable (ram_byteenable), .writedata (ram_writedata),
        .readdata (ram_readdata)
    );

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import ls_core_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     read,
    input  logic     write,
    input  addr_t    address,
    input  byte_en_t byteenable,
    input  word_t    writedata,
    output word_t    readdata
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = address[IDX_W+1:2];   // Word index, byte offset dropped

    always_ff @(posedge clk) begin
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[idx][8*b +: 8] <= writedata[8*b +: 8];
                end
            end
        end
        if (read) begin
            readdata <= mem[idx];   // Holds until the next read
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import ls_core_pkg::*; (
    input  logic     host_read,
    input  logic     host_write,
    input  addr_t    host_address,
    input  byte_en_t host_byteenable,
    input  word_t    host_writedata,
    output logic     host_waitrequest,
    input  logic     fetch_read,
    input  logic     fetch_write,
    input  addr_t    fetch_address,
    input  byte_en_t fetch_byteenable,
    input  word_t    fetch_writedata,
    output logic     fetch_waitrequest,
    input  logic     lsu_read,
    input  logic     lsu_write,
    input  addr_t    lsu_address,
    input  byte_en_t lsu_byteenable,
    input  word_t    lsu_writedata,
    output logic     lsu_waitrequest,
    output logic     ram_read,
    output logic     ram_write,
    output addr_t    ram_address,
    output byte_en_t ram_byteenable,
    output word_t    ram_writedata
);

    logic host_req, fetch_req, lsu_req;
    logic host_gnt, fetch_gnt, lsu_gnt;

    assign host_req  = host_read | host_write;
    assign fetch_req = fetch_read | fetch_write;
    assign lsu_req   = lsu_read | lsu_write;

    // Fixed priority host > fetch > lsu
    assign host_gnt  = host_req;
    assign fetch_gnt = fetch_req & ~host_req;
    assign lsu_gnt   = lsu_req & ~host_req & ~fetch_req;

    assign host_waitrequest  = 1'b0;       // Top priority is never held off
    assign fetch_waitrequest = host_req;   // Also paces the sequencer in EXEC1
    assign lsu_waitrequest   = lsu_req & ~lsu_gnt;

    always_comb begin
        ram_read       = 1'b0;
        ram_write      = 1'b0;
        ram_address    = lsu_address;
        ram_byteenable = lsu_byteenable;
        ram_writedata  = lsu_writedata;
        if (host_gnt) begin
            ram_read       = host_read;
            ram_write      = host_write;
            ram_address    = host_address;
            ram_byteenable = host_byteenable;
            ram_writedata  = host_writedata;
        end else if (fetch_gnt) begin
            ram_read       = fetch_read;
            ram_write      = fetch_write;
            ram_address    = fetch_address;
            ram_byteenable = fetch_byteenable;
            ram_writedata  = fetch_writedata;
        end else if (lsu_gnt) begin
            ram_read  = lsu_read;
            ram_write = lsu_write;
        end
    end

    a_one_grant: assert final ($onehot0({host_gnt, fetch_gnt, lsu_gnt}))
        else $error("more than one master granted");

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import ls_core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;   // Full word only
        end
    end

    // R0 reads zero whatever was written to it
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: hw/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import ls_core_pkg::*; (
    input  cpu_phase_e phase,
    input  ls_op_e     ls_op,
    input  reg_idx_t   rt,
    input  imm_t       offset,
    input  word_t      rs_data,          // Base register
    input  word_t      rt_data,          // Store source, old value for LWL/LWR
    input  word_t      mem_readdata,
    input  logic       mem_waitrequest,
    output logic       mem_read,
    output logic       mem_write,
    output addr_t      mem_address,
    output byte_en_t   mem_byteenable,
    output word_t      mem_writedata,
    output logic       reg_we,
    output reg_idx_t   reg_waddr,
    output word_t      reg_wdata
);

    logic        op_lb, op_lbu, op_lh, op_lhu, op_lui, op_lw;
    logic        op_lwl, op_lwr, op_sb, op_sh, op_sw;
    logic        is_load;
    logic        is_store;
    addr_t       eff_addr;
    logic [1:0]  lane;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign op_lb  = (ls_op == LB);
    assign op_lbu = (ls_op == LBU);
    assign op_lh  = (ls_op == LH);
    assign op_lhu = (ls_op == LHU);
    assign op_lui = (ls_op == LUI);
    assign op_lw  = (ls_op == LW);
    assign op_lwl = (ls_op == LWL);
    assign op_lwr = (ls_op == LWR);
    assign op_sb  = (ls_op == SB);
    assign op_sh  = (ls_op == SH);
    assign op_sw  = (ls_op == SW);

    assign is_load  = op_lb | op_lbu | op_lh | op_lhu | op_lw | op_lwl | op_lwr;
    assign is_store = op_sb | op_sh | op_sw;

    assign eff_addr    = rs_data + {{16{offset[15]}}, offset};
    assign lane        = eff_addr[1:0];
    assign mem_address = {eff_addr[31:2], 2'b00};   // Word aligned bus address
    assign reg_waddr   = rt;

    // Lane 0 is the most significant byte
    always_comb begin
        case (lane)
            2'd0:    ld_byte = mem_readdata[31:24];
            2'd1:    ld_byte = mem_readdata[23:16];
            2'd2:    ld_byte = mem_readdata[15:8];
            default: ld_byte = mem_readdata[7:0];
        endcase
    end

    assign ld_half = lane[1] ? mem_readdata[15:0] : mem_readdata[31:16];

    always_comb begin
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        mem_byteenable = 4'b1111;
        mem_writedata  = '0;
        reg_we         = 1'b0;
        reg_wdata      = '0;
        case (phase)
            EXEC1: begin
                mem_read  = is_load;
                mem_write = is_store;
                if (op_lb || op_lbu || op_sb) begin
                    mem_byteenable = 4'b1000 >> lane;
                end else if (op_lh || op_lhu || op_sh) begin
                    mem_byteenable = lane[1] ? 4'b0011 : 4'b1100;
                end else if (op_lwl) begin
                    mem_byteenable = 4'b1111 >> lane;
                end else if (op_lwr) begin
                    mem_byteenable = 4'b1111 << (2'd3 - lane);
                end
                if (op_sb) begin
                    mem_writedata = {rt_data[7:0], 24'h000000} >> {lane, 3'b000};
                end else if (op_sh) begin
                    mem_writedata = lane[1] ? {16'h0000, rt_data[15:0]}
                                            : {rt_data[15:0], 16'h0000};
                end else if (op_sw) begin
                    mem_writedata = rt_data;
                end
            end
            EXEC2: begin
                reg_we = (is_load || op_lui) && (rt != '0);   // R0 writes dropped
                if (op_lw) begin
                    reg_wdata = mem_readdata;
                end else if (op_lb) begin
                    reg_wdata = {{24{ld_byte[7]}}, ld_byte};
                end else if (op_lbu) begin
                    reg_wdata = {24'h000000, ld_byte};
                end else if (op_lh) begin
                    reg_wdata = {{16{ld_half[15]}}, ld_half};
                end else if (op_lhu) begin
                    reg_wdata = {16'h0000, ld_half};
                end else if (op_lui) begin
                    reg_wdata = {offset, 16'h0000};
                end else if (op_lwl) begin
                    case (lane)   // Memory bytes fill from the top
                        2'd0:    reg_wdata = mem_readdata;
                        2'd1:    reg_wdata = {mem_readdata[23:0], rt_data[7:0]};
                        2'd2:    reg_wdata = {mem_readdata[15:0], rt_data[15:0]};
                        default: reg_wdata = {mem_readdata[7:0], rt_data[23:0]};
                    endcase
                end else if (op_lwr) begin
                    case (lane)
                        2'd0:    reg_wdata = {rt_data[31:8], mem_readdata[31:24]};
                        2'd1:    reg_wdata = {rt_data[31:16], mem_readdata[31:16]};
                        2'd2:    reg_wdata = {rt_data[31:24], mem_readdata[31:8]};
                        default: reg_wdata = mem_readdata;
                    endcase
                end
            end
            default: ;
        endcase
    end

    a_rw_exclusive: assert final (!(mem_read && mem_write))
        else $error("LSU drives read and write together");

    // Arbiter only stalls the LSU while it requests, so never during write-back
    a_wb_not_stalled: assert final (!(reg_we && mem_waitrequest))
        else $error("write-back while the bus holds the LSU off");

endmodule

`default_nettype wire

// File: hw/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sequencer import ls_core_pkg::*; #(
    parameter addr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  word_t      mem_readdata,
    input  logic       mem_waitrequest,
    output cpu_phase_e phase,
    output word_t      instr,
    output addr_t      pc,
    output logic       mem_read,
    output addr_t      mem_address
);

    cpu_phase_e phase_nxt;
    word_t      ir;
    logic       ir_fresh;   // High while the fetched word is on readdata

    assign mem_read    = (phase == FETCH) && run;
    assign mem_address = pc;

    // Bypass so the LSU can issue in the same cycle the word arrives
    assign instr = ir_fresh ? mem_readdata : ir;

    always_comb begin
        phase_nxt = phase;
        case (phase)
            FETCH: begin
                if (run && !mem_waitrequest) begin
                    phase_nxt = EXEC1;
                end
            end
            EXEC1: begin
                if (!mem_waitrequest) begin   // Held while the host owns the RAM
                    phase_nxt = EXEC2;
                end
            end
            default: phase_nxt = FETCH;   // EXEC2 never stalls
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= FETCH;
            pc       <= RESET_PC;
            ir       <= '0;
            ir_fresh <= 1'b0;
        end else begin
            phase    <= phase_nxt;
            ir_fresh <= mem_read && !mem_waitrequest;
            // Captured once since later readdata may belong to a host read
            if (ir_fresh) begin
                ir <= mem_readdata;
                pc <= pc + 32'd4;
            end
        end
    end

    a_phase_legal: assert property (@(posedge clk) disable iff (!rst_n)
        phase inside {FETCH, EXEC1, EXEC2} && (!mem_read || phase == FETCH))
        else $error("illegal phase or fetch outside FETCH");

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import ls_core_pkg::*; (
    input  word_t    instr,
    output ls_op_e   ls_op,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output imm_t     offset
);

    // MIPS I primary opcodes
    localparam logic [5:0] OP_LUI = 6'h0f;
    localparam logic [5:0] OP_LB  = 6'h20;
    localparam logic [5:0] OP_LH  = 6'h21;
    localparam logic [5:0] OP_LWL = 6'h22;
    localparam logic [5:0] OP_LW  = 6'h23;
    localparam logic [5:0] OP_LBU = 6'h24;
    localparam logic [5:0] OP_LHU = 6'h25;
    localparam logic [5:0] OP_LWR = 6'h26;
    localparam logic [5:0] OP_SB  = 6'h28;
    localparam logic [5:0] OP_SH  = 6'h29;
    localparam logic [5:0] OP_SW  = 6'h2b;

    logic [5:0] opcode;

    // I-type fields
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];   // Base register
    assign rt     = instr[20:16];   // Target or store source
    assign offset = instr[15:0];

    always_comb begin
        case (opcode)
            OP_LB:   ls_op = LB;
            OP_LBU:  ls_op = LBU;
            OP_LH:   ls_op = LH;
            OP_LHU:  ls_op = LHU;
            OP_LUI:  ls_op = LUI;
            OP_LW:   ls_op = LW;
            OP_LWL:  ls_op = LWL;
            OP_LWR:  ls_op = LWR;
            OP_SB:   ls_op = SB;
            OP_SH:   ls_op = SH;
            OP_SW:   ls_op = SW;
            default: ls_op = NOP;   // Everything else retires silently
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ls_core_pkg.sv
`default_nettype none

package ls_core_pkg;

    typedef logic [31:0] word_t;      // Data word
    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [3:0]  byte_en_t;   // Bit 3 is the MSB lane in big-endian order
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;       // Instruction immediate field

    // Two-bit phase encoding
    typedef enum logic [1:0] {
        FETCH = 2'b00,
        EXEC1 = 2'b01,
        EXEC2 = 2'b10
    } cpu_phase_e;

    typedef enum logic [3:0] {
        NOP,
        LB,
        LBU,
        LH,
        LHU,
        LUI,
        LW,
        LWL,
        LWR,
        SB,
        SH,
        SW
    } ls_op_e;

endpackage

`default_nettype wire
